//--- sources.f
logic/rp_pkg.sv
logic/sys_bus_if.sv
logic/sys_bus_decode.sv
logic/hk_regs.sv
logic/analog_front.sv
logic/dac_gen.sv
logic/rp_lite_top.sv
tests/rp_tb.sv

//--- run_sim.sh
#!/bin/sh
# build rp_tb with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module rp_tb -o rp_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rp_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
exit 1

//--- tests/rp_tb.sv
// directed testbench for rp_lite_top with clock, reset, bus tasks, compare tasks, tests, watchdog
`default_nettype none

module rp_tb;
  import rp_pkg::*;

  localparam int        HALF_PERIOD = 50;
  localparam int        NUM_TESTS   = 6;
  localparam int        WD_CYCLES   = NUM_TESTS * 200 + 50;
  localparam int        ACK_WAIT    = 4;             // cycles allowed for a slave ack
  localparam sys_word_t HK_BASE     = 32'h0000_0000;
  localparam sys_word_t GEN_BASE    = 32'h0010_0000;
  localparam sys_word_t ADC_BASE    = 32'h0020_0000;

  logic      adc_clk;
  logic      rst_i;
  sys_word_t sys_addr_i;
  sys_word_t sys_wdata_i;
  logic      sys_wen_i;
  logic      sys_ren_i;
  sys_word_t sys_rdata_o;
  logic      sys_ack_o;
  logic      sys_err_o;
  raw_code_t adc_dat_a_i;
  raw_code_t adc_dat_b_i;
  raw_code_t dac_dat_a_o;
  raw_code_t dac_dat_b_o;
  logic      ps_led_en_i;
  led_t      ps_led_data_i;
  led_t      led_o;

  int     mismatch_cnt;
  int     fail_cnt;   // missing acks
  int     last_lat;   // ack latency of the last access or -1 when none came
  integer seed;

  rp_lite_top u_dut (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o),
    .adc_dat_a_i   (adc_dat_a_i),
    .adc_dat_b_i   (adc_dat_b_i),
    .dac_dat_a_o   (dac_dat_a_o),
    .dac_dat_b_o   (dac_dat_b_o),
    .ps_led_en_i   (ps_led_en_i),
    .ps_led_data_i (ps_led_data_i),
    .led_o         (led_o)
  );

  always #HALF_PERIOD adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  // neg-slope code and two's complement differ in the low 13 bits only
  function automatic raw_code_t code_of(sample_t s);
    return raw_code_t'(s) ^ 14'h1FFF;
  endfunction

  function automatic sample_t sample_of(raw_code_t c);
    return sample_t'(c ^ 14'h1FFF);
  endfunction

  function automatic sys_word_t sext(sample_t s);
    return {{(32-ADC_W){s[ADC_W-1]}}, s};
  endfunction

  function automatic sample_t clamp_sum(sample_t level, sample_t smp);
    int s;
    s = int'(level) + int'(smp);  // exact sum then clip to 14 bits
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(input sys_word_t got, input sys_word_t exp, input string msg);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_dac(input raw_code_t got, input raw_code_t exp, input string msg);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp, input string msg);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////////////////////////
  task automatic bus_access(input logic wr, input sys_word_t addr, input sys_word_t wdata,
                            output sys_word_t rdata, output logic err);
    int   waited;
    logic got;
    waited   = 0;
    got      = 1'b0;
    rdata    = '0;
    err      = 1'b0;
    last_lat = -1;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    #1;
    if (sys_ack_o)  // empty regions answer in the strobe cycle
    begin
      got      = 1'b1;
      last_lat = 0;
      rdata    = sys_rdata_o;
      err      = sys_err_o;
    end
    @(negedge adc_clk);
    sys_wen_i = 1'b0;  // one-cycle strobe
    sys_ren_i = 1'b0;
    while (!got && waited < ACK_WAIT)
    begin
      #1;
      waited++;
      if (sys_ack_o)
      begin
        got      = 1'b1;
        last_lat = waited;
        rdata    = sys_rdata_o;
        err      = sys_err_o;
      end
      else
        @(negedge adc_clk);
    end
    if (!got)
    begin
      fail_cnt++;
      $display("%0t: ack missing, no answer within %0d cycles to the %s at address %h",
               $time, ACK_WAIT, wr ? "write" : "read", addr);
    end
  endtask

  task automatic bus_write(input sys_word_t addr, input sys_word_t data, output logic err);
    sys_word_t unused_rd;
    bus_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic bus_read(input sys_word_t addr, output sys_word_t data, output logic err);
    bus_access(1'b0, addr, '0, data, err);
  endtask

  task automatic write_reg(input sys_word_t addr, input sys_word_t data, input logic exp_err);
    logic err;
    bus_write(addr, data, err);
    check_flag(err, exp_err, $sformatf("err on write to %h", addr));
  endtask

  task automatic read_back(input sys_word_t addr, input sys_word_t exp, input string msg);
    sys_word_t data;
    logic      err;
    bus_read(addr, data, err);
    check_word(data, exp, msg);
    check_flag(err, 1'b0, $sformatf("err on read of %h", addr));
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_state();
    #1;
    check_flag(sys_ack_o, 1'b0, "ack after reset");
    check_flag(sys_err_o, 1'b0, "err after reset");
    check_dac(dac_dat_a_o, 14'h1FFF, "dac a after reset");  // zero sample
    check_dac(dac_dat_b_o, 14'h1FFF, "dac b after reset");
    check_led(led_o, 8'h00, "led after reset");
    read_back(HK_BASE, HK_ID, "hk id");
    check_word(sys_word_t'(last_lat), 32'd1, "hk ack latency");
    write_reg(HK_BASE, 32'hFFFF_FFFF, 1'b1);  // id is read-only
    read_back(HK_BASE, HK_ID, "hk id after write");
  endtask

  task automatic region_decode();
    sys_word_t r;
    write_reg(HK_BASE | 32'h4, 32'hFFFF_FFFE, 1'b0);
    read_back(HK_BASE | 32'h4, 32'h0, "loop bit 0");
    write_reg(HK_BASE | 32'h4, 32'hFFFF_FFFF, 1'b0);
    read_back(HK_BASE | 32'h4, 32'h1, "loop bit 1");  // masked to one bit
    write_reg(HK_BASE | 32'h4, 32'h0, 1'b0);
    r = $random(seed);
    write_reg(HK_BASE | 32'h8, r, 1'b0);
    read_back(HK_BASE | 32'h8, {24'h0, r[7:0]}, "led register");
    write_reg(HK_BASE | 32'hC, ~r | 32'h1, 1'b0);  // unmapped offset stores nothing
    read_back(HK_BASE | 32'h8, {24'h0, r[7:0]}, "led after unmapped write");
    read_back(HK_BASE | 32'h4, 32'h0, "loop after unmapped write");
    for (int reg_n = 3; reg_n < 8; reg_n++)
    begin
      r = (sys_word_t'(reg_n) << REGION_LSB) | (sys_word_t'($random(seed)) & 32'h000F_FFFC);
      read_back(r, 32'h0, $sformatf("empty region %0d", reg_n));
      check_word(sys_word_t'(last_lat), 32'd0, "empty region ack latency");
    end
    write_reg(32'h0050_0004, 32'hDEAD_BEEF, 1'b0);
    check_word(sys_word_t'(last_lat), 32'd0, "empty region write latency");
    // offsets without a register
    read_back(HK_BASE | 32'hC, 32'h0, "hk offset 3");
    read_back(GEN_BASE | 32'hC, 32'h0, "gen offset 3");
    read_back(ADC_BASE | 32'h8, 32'h0, "adc offset 2");
    read_back(HK_BASE | 32'h100, 32'h0, "hk page bits set");
  endtask

  task automatic adc_conversion();
    raw_code_t ca;
    raw_code_t cb;
    for (int i = 0; i < 8; i++)
    begin
      ca = raw_code_t'($random(seed));
      cb = raw_code_t'($random(seed));
      @(negedge adc_clk);
      adc_dat_a_i = ca;
      adc_dat_b_i = cb;
      repeat (3) @(negedge adc_clk);  // pin reg then readback reg
      read_back(ADC_BASE, sext(sample_of(ca)), "adc a readback");
      check_word(sys_word_t'(last_lat), 32'd1, "adc ack latency");
      read_back(ADC_BASE | 32'h4, sext(sample_of(cb)), "adc b readback");
    end
    write_reg(ADC_BASE, 32'h1, 1'b1);  // whole region read-only
  endtask

  // drive levels and pin samples and check the dac codes once the path has settled
  task automatic sum_case(input logic feed, input sample_t lvl_a, input sample_t smp_a,
                          input sample_t lvl_b, input sample_t smp_b);
    @(negedge adc_clk);
    adc_dat_a_i = code_of(smp_a);
    adc_dat_b_i = code_of(smp_b);
    write_reg(GEN_BASE, sext(lvl_a), 1'b0);
    check_word(sys_word_t'(last_lat), 32'd1, "gen ack latency");
    write_reg(GEN_BASE | 32'h4, sext(lvl_b), 1'b0);
    repeat (2) @(negedge adc_clk);
    #1;
    check_dac(dac_dat_a_o, code_of(feed ? clamp_sum(lvl_a, smp_a) : lvl_a), "dac a code");
    check_dac(dac_dat_b_o, code_of(feed ? clamp_sum(lvl_b, smp_b) : lvl_b), "dac b code");
  endtask

  task automatic dac_sum();
    write_reg(GEN_BASE | 32'h8, 32'h0, 1'b0);  // dc only
    for (int i = 0; i < 6; i++)
      sum_case(1'b0, sample_t'($random(seed)), sample_t'($random(seed)),
               sample_t'($random(seed)), sample_t'($random(seed)));
    write_reg(GEN_BASE | 32'h8, 32'h3, 1'b0);  // both feed bits
    sum_case(1'b1, 14'sd8000, 14'sd1000, -14'sd8000, -14'sd1000);  // clamp high and low
    sum_case(1'b1, -14'sd8000, -14'sd1000, 14'sd8000, 14'sd1000);
    sum_case(1'b1, 14'sd8191, 14'sd8191, -14'sd8192, -14'sd8192);
    sum_case(1'b1, -14'sd8192, 14'sd8191, 14'sd100, -14'sd200);
    for (int i = 0; i < 6; i++)
      sum_case(1'b1, sample_t'($random(seed)), sample_t'($random(seed)),
               sample_t'($random(seed)), sample_t'($random(seed)));
    write_reg(GEN_BASE | 32'h8, 32'h0, 1'b0);
  endtask

  task automatic digital_loop();
    sample_t la;
    sample_t lb;
    la = sample_t'($random(seed));
    lb = sample_t'($random(seed));
    write_reg(GEN_BASE | 32'h8, 32'h0, 1'b0);  // no feed so the loop stays bounded
    write_reg(GEN_BASE, sext(la), 1'b0);
    write_reg(GEN_BASE | 32'h4, sext(lb), 1'b0);
    write_reg(HK_BASE | 32'h4, 32'h1, 1'b0);
    for (int i = 0; i < 2; i++)
    begin
      @(negedge adc_clk);
      adc_dat_a_i = raw_code_t'($random(seed));  // pins must not matter
      adc_dat_b_i = raw_code_t'($random(seed));
      repeat (4) @(negedge adc_clk);
      read_back(ADC_BASE, sext(la), "looped sample a");
      read_back(ADC_BASE | 32'h4, sext(lb), "looped sample b");
      check_dac(dac_dat_a_o, code_of(la), "dac a in loop");
      check_dac(dac_dat_b_o, code_of(lb), "dac b in loop");
    end
    write_reg(HK_BASE | 32'h4, 32'h0, 1'b0);
  endtask

  task automatic led_mux();
    led_t hk_led;
    led_t ps_led;
    hk_led = led_t'($random(seed));
    write_reg(HK_BASE | 32'h8, {24'h0, hk_led}, 1'b0);
    check_led(led_o, hk_led, "led from hk");
    for (int i = 0; i < 3; i++)
    begin
      ps_led = led_t'($random(seed));
      @(negedge adc_clk);
      ps_led_en_i   = 1'b1;
      ps_led_data_i = ps_led;
      #1;
      check_led(led_o, ps_led, "led from ps");
    end
    read_back(HK_BASE | 32'h8, {24'h0, hk_led}, "hk led under ps override");
    @(negedge adc_clk);
    ps_led_en_i = 1'b0;
    #1;
    check_led(led_o, hk_led, "led back to hk");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    adc_clk       = 1'b0;
    rst_i         = 1'b1;
    sys_addr_i    = '0;
    sys_wdata_i   = '0;
    sys_wen_i     = 1'b0;
    sys_ren_i     = 1'b0;
    adc_dat_a_i   = '0;
    adc_dat_b_i   = '0;
    ps_led_en_i   = 1'b0;
    ps_led_data_i = '0;
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    last_lat      = -1;
    seed          = 32'h3a70_ad13;
    repeat (5) @(negedge adc_clk);
    rst_i = 1'b0;
    reset_state();
    region_decode();
    adc_conversion();
    dac_sum();
    digital_loop();
    led_mux();
    $display("errors: %0d mismatches, %0d missing acks", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge adc_clk);
    $display("watchdog expired, tests did not finish within %0d cycles", WD_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/rp_lite_top.sv
// adc clock domain top, bus decoder with housekeeping, analog front and dac generator
`default_nettype none

module rp_lite_top (
  input  logic              adc_clk,
  input  logic              rst_i,
  // system bus
  input  rp_pkg::sys_word_t sys_addr_i,
  input  rp_pkg::sys_word_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::sys_word_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // converters
  input  rp_pkg::raw_code_t adc_dat_a_i,
  input  rp_pkg::raw_code_t adc_dat_b_i,
  output rp_pkg::raw_code_t dac_dat_a_o,
  output rp_pkg::raw_code_t dac_dat_b_o,
  // leds
  input  logic              ps_led_en_i,
  input  rp_pkg::led_t      ps_led_data_i,
  output rp_pkg::led_t      led_o
);
  import rp_pkg::*;

  sample_t adc_a, adc_b;  // converted or looped samples
  sample_t dac_a, dac_b;  // registered dac samples
  logic    digital_loop;

  sys_bus_if hk_bus ();
  sys_bus_if gen_bus ();
  sys_bus_if adc_bus ();

  ////////////////////////////////////////////////////////////////////
  // decode, housekeeping, execute, result
  ////////////////////////////////////////////////////////////////////
  sys_bus_decode u_decode (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_bus      (hk_bus),
    .gen_bus     (gen_bus),
    .adc_bus     (adc_bus)
  );

  hk_regs u_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (hk_bus),
    .ps_led_en_i    (ps_led_en_i),
    .ps_led_data_i  (ps_led_data_i),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  analog_front u_front (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (adc_bus),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),  // loop back source
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_gen u_gen (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .bus         (gen_bus),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

//--- logic/dac_gen.sv
// dc level generator, adc feed-through, sum with saturation and dac code output
`default_nettype none

module dac_gen (
  input  logic              adc_clk,
  input  logic              rst_i,
  sys_bus_if.slave          bus,
  input  rp_pkg::sample_t   adc_a_i,
  input  rp_pkg::sample_t   adc_b_i,
  output rp_pkg::sample_t   dac_a_o,      // registered sample, also loop source
  output rp_pkg::sample_t   dac_b_o,
  output rp_pkg::raw_code_t dac_dat_a_o,  // neg-slope pin code
  output rp_pkg::raw_code_t dac_dat_b_o
);
  import rp_pkg::*;

  sample_t                dc_a, dc_b;      // dc levels
  logic                   feed_a, feed_b;  // unity feed-through enables
  sample_t                add_a, add_b;
  logic signed [ADC_W:0]  sum_a, sum_b;    // one guard bit
  sample_t                dac_q_a, dac_q_b;
  reg_off_e               off;
  logic                   hit;
  sys_word_t              rd_val;
  sys_word_t              rdata_q;
  logic                   ack_q;

  // clamp when the two top bits of the sum disagree
  function automatic sample_t sat(logic signed [ADC_W:0] s);
    if (s[ADC_W] != s[ADC_W-1])
      return s[ADC_W] ? SAT_MIN : SAT_MAX;
    return s[ADC_W-1:0];
  endfunction

  assign off = addr_off(bus.addr);
  assign hit = page_hit(bus.addr);

  ////////////////////////////////////////////////////////////////////
  // registers and dac sample
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dc_a    <= '0;
      dc_b    <= '0;
      feed_a  <= 1'b0;
      feed_b  <= 1'b0;
      dac_q_a <= '0;
      dac_q_b <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q   <= bus.wen | bus.ren;
      dac_q_a <= sat(sum_a);
      dac_q_b <= sat(sum_b);
      if (bus.wen && hit)
      begin
        case (off)
          OFF_0:   dc_a <= bus.wdata[ADC_W-1:0];
          OFF_1:   dc_b <= bus.wdata[ADC_W-1:0];
          OFF_2:   {feed_b, feed_a} <= bus.wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  assign add_a = feed_a ? adc_a_i : sample_t'(0);
  assign add_b = feed_b ? adc_b_i : sample_t'(0);
  assign sum_a = dc_a + add_a;  // signed, extended to 15 bits
  assign sum_b = dc_b + add_b;

  always_comb
  begin
    rd_val = '0;
    if (hit)
    begin
      case (off)
        OFF_0:   rd_val = sys_word_t'(dc_a);
        OFF_1:   rd_val = sys_word_t'(dc_b);
        OFF_2:   rd_val = sys_word_t'({feed_b, feed_a});
        default: rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= bus.ren ? rd_val : '0;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;  // all registers writable
  assign bus.rdata = rdata_q;

  assign dac_a_o     = dac_q_a;
  assign dac_b_o     = dac_q_b;
  assign dac_dat_a_o = neg_slope(dac_q_a);  // back to neg-slope
  assign dac_dat_b_o = neg_slope(dac_q_b);

endmodule

`default_nettype wire

//--- logic/analog_front.sv
// adc pin capture, neg-slope conversion, digital loop mux and sample readback
`default_nettype none

module analog_front (
  input  logic              adc_clk,
  input  logic              rst_i,
  sys_bus_if.slave          bus,
  input  rp_pkg::raw_code_t adc_dat_a_i,
  input  rp_pkg::raw_code_t adc_dat_b_i,
  input  logic              digital_loop_i,  // take dac samples instead of pins
  input  rp_pkg::sample_t   dac_a_i,
  input  rp_pkg::sample_t   dac_b_i,
  output rp_pkg::sample_t   adc_a_o,
  output rp_pkg::sample_t   adc_b_o
);
  import rp_pkg::*;

  raw_code_t raw_a, raw_b;  // io registers
  sample_t   smp_a, smp_b;  // readback copies
  sys_word_t rd_val;
  sys_word_t rdata_q;
  logic      ack_q;
  logic      err_q;

  always_ff @(posedge adc_clk)
  begin
    raw_a <= adc_dat_a_i;
    raw_b <= adc_dat_b_i;
    smp_a <= adc_a_o;  // one edge behind the converted sample
    smp_b <= adc_b_o;
  end

  // unsigned neg-slope -> two's complement, or loop back the dac
  assign adc_a_o = digital_loop_i ? dac_a_i : sample_t'(neg_slope(raw_a));
  assign adc_b_o = digital_loop_i ? dac_b_i : sample_t'(neg_slope(raw_b));

  ////////////////////////////////////////////////////////////////////
  // readback, whole region is read-only
  ////////////////////////////////////////////////////////////////////
  always_comb
  begin
    rd_val = '0;
    if (page_hit(bus.addr))
    begin
      case (addr_off(bus.addr))
        OFF_0:   rd_val = sys_word_t'(smp_a);  // sign extended
        OFF_1:   rd_val = sys_word_t'(smp_b);
        default: rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus.wen | bus.ren;
      err_q <= bus.wen;  // any write here is an error
    end
    rdata_q <= bus.ren ? rd_val : '0;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/hk_regs.sv
// housekeeping registers (id, digital loop, led data) and the led override mux
`default_nettype none

module hk_regs (
  input  logic          adc_clk,
  input  logic          rst_i,
  sys_bus_if.slave      bus,
  input  logic          ps_led_en_i,    // ps takes over the leds
  input  rp_pkg::led_t  ps_led_data_i,
  output logic          digital_loop_o,
  output rp_pkg::led_t  led_o
);
  import rp_pkg::*;

  reg_off_e  off;
  logic      hit;      // inside the register page
  logic      loop_q;   // dac -> adc loop switch
  led_t      led_q;
  sys_word_t rd_val;
  sys_word_t rdata_q;
  logic      ack_q;
  logic      err_q;

  assign off = addr_off(bus.addr);
  assign hit = page_hit(bus.addr);

  ////////////////////////////////////////////////////////////////////
  // register writes and bus response
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      ack_q <= bus.wen | bus.ren;
      err_q <= bus.wen & hit & (off == OFF_0);  // id is read-only
      if (bus.wen && hit)
      begin
        case (off)
          OFF_1:   loop_q <= bus.wdata[0];
          OFF_2:   led_q  <= bus.wdata[7:0];
          default: ;  // id and unmapped, nothing stored
        endcase
      end
    end
  end

  always_comb
  begin
    rd_val = '0;  // unmapped reads zero
    if (hit)
    begin
      case (off)
        OFF_0:   rd_val = HK_ID;
        OFF_1:   rd_val = sys_word_t'(loop_q);
        OFF_2:   rd_val = sys_word_t'(led_q);
        default: rd_val = '0;
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= bus.ren ? rd_val : '0;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.rdata = rdata_q;

  assign digital_loop_o = loop_q;
  assign led_o = ps_led_en_i ? ps_led_data_i : led_q;  // ps wins over hk

endmodule

`default_nettype wire

//--- logic/sys_bus_decode.sv
// system bus decoder, region strobe routing and read-data / ack / err return mux
`default_nettype none

module sys_bus_decode (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sys_word_t sys_addr_i,
  input  rp_pkg::sys_word_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::sys_word_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  sys_bus_if.decoder        hk_bus,
  sys_bus_if.decoder        gen_bus,
  sys_bus_if.decoder        adc_bus
);
  import rp_pkg::*;

  logic [REGION_N-1:0] region_sel;  // one-hot region
  region_e             region;      // region of the current address
  region_e             region_q;    // region of the outstanding access
  logic                unused_hit;  // strobe into regions 3..7

  assign region     = region_e'(sys_addr_i[REGION_LSB +: REGION_W]);
  assign region_sel = {{(REGION_N-1){1'b0}}, 1'b1} << sys_addr_i[REGION_LSB +: REGION_W];

  // address and data fan out to all, strobes only to the selected one
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.wen    = sys_wen_i & region_sel[REG_HK];
  assign hk_bus.ren    = sys_ren_i & region_sel[REG_HK];
  assign gen_bus.addr  = sys_addr_i;
  assign gen_bus.wdata = sys_wdata_i;
  assign gen_bus.wen   = sys_wen_i & region_sel[REG_GEN];
  assign gen_bus.ren   = sys_ren_i & region_sel[REG_GEN];
  assign adc_bus.addr  = sys_addr_i;
  assign adc_bus.wdata = sys_wdata_i;
  assign adc_bus.wen   = sys_wen_i & region_sel[REG_ADC];
  assign adc_bus.ren   = sys_ren_i & region_sel[REG_ADC];

  assign unused_hit = (sys_wen_i | sys_ren_i) &
                      ~(region_sel[REG_HK] | region_sel[REG_GEN] | region_sel[REG_ADC]);

  // slave answers one cycle later, so remember who was asked
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      region_q <= REG_HK;
    else if (sys_wen_i || sys_ren_i)
      region_q <= region;
  end

  ////////////////////////////////////////////////////////////////////
  // return path
  ////////////////////////////////////////////////////////////////////
  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (unused_hit)
    begin
      sys_ack_o = 1'b1;  // empty region, same-cycle ack, zero data
    end
    else
    begin
      case (region_q)
        REG_HK:  {sys_rdata_o, sys_ack_o, sys_err_o} = {hk_bus.rdata, hk_bus.ack, hk_bus.err};
        REG_GEN: {sys_rdata_o, sys_ack_o, sys_err_o} = {gen_bus.rdata, gen_bus.ack, gen_bus.err};
        REG_ADC: {sys_rdata_o, sys_ack_o, sys_err_o} = {adc_bus.rdata, adc_bus.ack, adc_bus.err};
        default: sys_ack_o = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/sys_bus_if.sv
// per-region system bus, decoder and slave views
`default_nettype none

interface sys_bus_if;
  import rp_pkg::*;

  sys_word_t addr;   // full address, slave uses the low bits
  sys_word_t wdata;
  logic      wen;    // one-cycle write strobe
  logic      ren;    // one-cycle read strobe
  sys_word_t rdata;  // valid with ack
  logic      ack;    // one cycle after the strobe
  logic      err;    // write to a read-only register

  modport decoder (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

//--- logic/rp_pkg.sv
// shared bus widths, region and offset enums, sample types, constants and helpers
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////////////
  localparam int unsigned SYS_ADDR_W = 32;
  localparam int unsigned SYS_DATA_W = 32;

  // one word type for addr, wdata and rdata, wide enough for either
  typedef logic [((SYS_ADDR_W > SYS_DATA_W) ? SYS_ADDR_W : SYS_DATA_W)-1:0] sys_word_t;

  localparam int unsigned REGION_LSB = 20;  // region field is addr[22:20]
  localparam int unsigned REGION_W   = 3;
  localparam int unsigned REGION_N   = 8;

  typedef enum logic [REGION_W-1:0] {
    REG_HK  = 3'd0,  // housekeeping
    REG_GEN = 3'd1,  // dc generator / dac path
    REG_ADC = 3'd2   // adc sample readback
  } region_e;  // 3..7 unused, answered by the decoder

  typedef enum logic [1:0] {
    OFF_0 = 2'd0,
    OFF_1 = 2'd1,
    OFF_2 = 2'd2
  } reg_off_e;  // addr[3:2] inside a region

  ////////////////////////////////////////////////////////////////////
  // samples
  ////////////////////////////////////////////////////////////////////
  localparam int unsigned ADC_W = 14;

  typedef logic        [ADC_W-1:0] raw_code_t;  // unsigned, negative slope
  typedef logic signed [ADC_W-1:0] sample_t;    // two's complement

  localparam sample_t SAT_MAX = sample_t'(8191);
  localparam sample_t SAT_MIN = sample_t'(-8192);

  typedef logic [7:0] led_t;

  localparam sys_word_t HK_ID = 32'h5250_0a01;  // board id word

  // neg-slope code <-> two's complement, same mapping both ways
  function automatic logic [ADC_W-1:0] neg_slope(logic [ADC_W-1:0] x);
    return {x[ADC_W-1], ~x[ADC_W-2:0]};  // keep msb, flip the rest
  endfunction

  function automatic reg_off_e addr_off(sys_word_t a);
    return reg_off_e'(a[3:2]);
  endfunction

  // bits between the offset and the region field must be zero
  function automatic logic page_hit(sys_word_t a);
    return a[REGION_LSB-1:4] == '0;
  endfunction

endpackage

`default_nettype wire
